// ==== hdl/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// machine word width for the rv32i integer path
`define RV_XLEN 32

// architectural integer registers x0..x31
`define RV_REG_COUNT 32

// width of the rs1/rs2/rd index fields
`define RV_REG_ADDR_W 5

`endif

// ==== hdl/rv_pkg.sv ====
`include "rv_settings.svh"

package rv_pkg;

	// operand, result, pc and branch target
	typedef logic [`RV_XLEN-1:0] word_t;

	// register index as carried in the instruction fields
	typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

	// raw 12-bit immediate field of the i-format
	typedef logic [11:0] imm12_t;

	// alu control code, same numbering as the older alu
	typedef enum logic [3:0] {
		alu_add    = 4'b0000,
		alu_sub    = 4'b0001,
		alu_sll    = 4'b0010,
		alu_slt    = 4'b0011,
		alu_sltu   = 4'b0100,
		alu_xor    = 4'b0101,
		alu_srl    = 4'b0110,
		alu_sra    = 4'b0111,
		alu_or     = 4'b1000,
		alu_and    = 4'b1001,
		alu_pass_b = 4'b1010
	} alu_op_e;

	// what the top does with a decoded instruction
	typedef enum logic [1:0] {
		cls_write   = 2'd0,
		cls_branch  = 2'd1,
		cls_illegal = 2'd2
	} inst_class_e;

	// major opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	// funct3 for OP / OP-IMM
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct3 for BRANCH
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// funct7 variants
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

// ==== hdl/alu.sv ====
module alu
	import rv_pkg::*;
(
	input  word_t   src1,
	input  word_t   src2,
	input  alu_op_e alu_op,
	output word_t   result,
	output logic    zero
);

	localparam int XLEN = $bits(word_t);

	// shift amount, only the low five bits count in rv32i
	logic [4:0] shamt;
	// src1 - src2 as src1 + ~src2 + 1, with carry out
	word_t      diff;
	logic       carry;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt = src2[4:0];

	// one subtractor serves sub, slt and sltu
	assign {carry, diff} = {1'b0, src1} + {1'b0, ~src2} + 1'b1;

	// no carry out means a borrow, so src1 < src2 unsigned
	assign lt_unsigned = ~carry;

	// signs differ: the negative one is smaller
	// signs equal: the difference cannot overflow, its sign decides
	assign lt_signed = (src1[XLEN-1] != src2[XLEN-1]) ? src1[XLEN-1] : diff[XLEN-1];

	// operation mux
	always_comb begin
		case (alu_op)
			alu_add: begin
				result = src1 + src2;
			end
			alu_sub: begin
				result = diff;
			end
			alu_sll: begin
				result = src1 << shamt;
			end
			alu_slt: begin
				result = {{(XLEN-1){1'b0}}, lt_signed};
			end
			alu_sltu: begin
				result = {{(XLEN-1){1'b0}}, lt_unsigned};
			end
			alu_xor: begin
				result = src1 ^ src2;
			end
			alu_srl: begin
				result = src1 >> shamt;
			end
			alu_sra: begin
				// arithmetic shift keeps the sign bit
				result = $signed(src1) >>> shamt;
			end
			alu_or: begin
				result = src1 | src2;
			end
			alu_and: begin
				result = src1 & src2;
			end
			alu_pass_b: begin
				// lui path, operand b is the u-immediate
				result = src2;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// zero flag over the full result, used for beq/bne
	assign zero = (result == '0);

	// the decoder always hands over a defined code, even for an x instruction
	always_comb begin
		assert final (!$isunknown(alu_op))
			else $error("alu: alu_op is unknown");
	end

endmodule

// ==== hdl/inst_decode.sv ====
module inst_decode
	import rv_pkg::*;
(
	input  word_t       instr,
	output reg_addr_t   rs1,
	output reg_addr_t   rs2,
	output reg_addr_t   rd,
	output word_t       imm,
	output alu_op_e     alu_op,
	output logic        use_imm,
	output logic [2:0]  branch_funct,
	output inst_class_e inst_class
);

	localparam int XLEN = $bits(word_t);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	imm12_t     imm_i_raw;
	word_t      imm_i;
	word_t      imm_u;
	word_t      imm_b;

	// funct3 to alu code, shared by OP and OP-IMM
	// alt selects sub / sra where funct7 allows it
	function automatic alu_op_e f3_to_op(input logic [2:0] f3, input logic alt);
		alu_op_e op;
		case (f3)
			F3_ADD_SUB: op = alt ? alu_sub : alu_add;
			F3_SLL:     op = alu_sll;
			F3_SLT:     op = alu_slt;
			F3_SLTU:    op = alu_sltu;
			F3_XOR:     op = alu_xor;
			F3_SRL_SRA: op = alt ? alu_sra : alu_srl;
			F3_OR:      op = alu_or;
			default:    op = alu_and;
		endcase
		return op;
	endfunction

	// fixed field positions
	assign opcode = instr[6:0];
	assign rd     = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign funct7 = instr[31:25];

	assign branch_funct = funct3;

	// immediates, all sign extended from instr[31]
	assign imm_i_raw = instr[31:20];
	assign imm_i = {{(XLEN-12){imm_i_raw[11]}}, imm_i_raw};
	assign imm_u = {instr[31:12], 12'b0};
	// b-format scatters the offset, bit 0 is always zero
	assign imm_b = {{(XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

	always_comb begin
		// defaults cover unknown opcodes
		imm        = '0;
		alu_op     = alu_add;
		use_imm    = 1'b0;
		inst_class = cls_illegal;

		case (opcode)
			OPC_OP: begin
				alu_op = f3_to_op(funct3, funct7 == F7_ALT);
				// alt encoding only valid for add/sub and srl/sra
				if (funct7 == F7_BASE) begin
					inst_class = cls_write;
				end else if (funct7 == F7_ALT &&
					(funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA)) begin
					inst_class = cls_write;
				end
			end
			OPC_OP_IMM: begin
				imm     = imm_i;
				use_imm = 1'b1;
				// no subi, funct7 only matters for the shifts
				alu_op  = f3_to_op(funct3, (funct3 == F3_SRL_SRA) && (funct7 == F7_ALT));
				inst_class = cls_write;
				if (funct3 == F3_SLL && funct7 != F7_BASE) begin
					inst_class = cls_illegal;
				end
				if (funct3 == F3_SRL_SRA && funct7 != F7_BASE && funct7 != F7_ALT) begin
					inst_class = cls_illegal;
				end
			end
			OPC_LUI: begin
				imm        = imm_u;
				use_imm    = 1'b1;
				alu_op     = alu_pass_b;
				inst_class = cls_write;
			end
			OPC_BRANCH: begin
				// operands come from rs1/rs2, imm is the target offset
				imm        = imm_b;
				inst_class = cls_branch;
				case (funct3)
					F3_BEQ, F3_BNE:   alu_op = alu_sub;
					F3_BLT, F3_BGE:   alu_op = alu_slt;
					F3_BLTU, F3_BGEU: alu_op = alu_sltu;
					default:          inst_class = cls_illegal;
				endcase
			end
			default: begin
				inst_class = cls_illegal;
			end
		endcase
	end

endmodule

// ==== hdl/reg_file.sv ====
`include "rv_settings.svh"

module reg_file
	import rv_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      we,
	input  reg_addr_t waddr,
	input  word_t     wdata,
	input  reg_addr_t raddr1,
	input  reg_addr_t raddr2,
	output word_t     rdata1,
	output word_t     rdata2
);

	word_t regs [`RV_REG_COUNT];

	// synchronous write, x0 never written
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `RV_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	// combinational reads
	// a write lands at the edge, the next cycle sees it
	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

	// write enable comes from valid and decoded class in the top
	a_we_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(we))
		else $error("reg_file: write enable unknown");

endmodule

// ==== hdl/exec_unit.sv ====
module exec_unit
	import rv_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      instr_valid,
	input  word_t     instr,
	input  word_t     pc,
	output logic      wb_valid,
	output reg_addr_t wb_rd,
	output word_t     wb_data,
	output logic      br_valid,
	output logic      br_taken,
	output word_t     br_target,
	output logic      illegal
);

	reg_addr_t   rs1;
	reg_addr_t   rs2;
	reg_addr_t   rd;
	word_t       imm;
	alu_op_e     alu_op;
	logic        use_imm;
	logic [2:0]  branch_funct;
	inst_class_e inst_class;

	word_t       rs1_data;
	word_t       rs2_data;
	word_t       src2;
	word_t       result;
	logic        zero;

	logic        issue_write;
	logic        issue_branch;
	logic        issue_illegal;
	logic        br_cond;
	word_t       target;

	inst_decode decode_i (
		.instr        (instr),
		.rs1          (rs1),
		.rs2          (rs2),
		.rd           (rd),
		.imm          (imm),
		.alu_op       (alu_op),
		.use_imm      (use_imm),
		.branch_funct (branch_funct),
		.inst_class   (inst_class)
	);

	// write port shares the edge that registers the result
	reg_file regs_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.we     (issue_write),
		.waddr  (rd),
		.wdata  (result),
		.raddr1 (rs1),
		.raddr2 (rs2),
		.rdata1 (rs1_data),
		.rdata2 (rs2_data)
	);

	// operand b is the immediate for OP-IMM and lui
	assign src2 = use_imm ? imm : rs2_data;

	alu alu_i (
		.src1   (rs1_data),
		.src2   (src2),
		.alu_op (alu_op),
		.result (result),
		.zero   (zero)
	);

	assign issue_write   = instr_valid && (inst_class == cls_write);
	assign issue_branch  = instr_valid && (inst_class == cls_branch);
	assign issue_illegal = instr_valid && (inst_class == cls_illegal);

	// condition from the alu flags
	// beq/bne look at zero after sub, the rest at bit 0 of slt/sltu
	always_comb begin
		case (branch_funct)
			F3_BEQ:  br_cond = zero;
			F3_BNE:  br_cond = ~zero;
			F3_BLT:  br_cond = result[0];
			F3_BGE:  br_cond = ~result[0];
			F3_BLTU: br_cond = result[0];
			F3_BGEU: br_cond = ~result[0];
			default: br_cond = 1'b0;
		endcase
	end

	// pc-relative target
	assign target = pc + imm;

	// output strobes, one cycle each
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			br_valid <= 1'b0;
			illegal  <= 1'b0;
		end else begin
			wb_valid <= issue_write;
			br_valid <= issue_branch;
			illegal  <= issue_illegal;
		end
	end

	// payload, qualified by the strobes above
	always_ff @(posedge clk) begin
		wb_rd     <= rd;
		wb_data   <= result;
		br_taken  <= br_cond;
		br_target <= target;
	end

	// decode class is exclusive, so only one pulse per cycle
	a_one_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({wb_valid, br_valid, illegal}))
		else $error("exec_unit: more than one output pulse");

endmodule

// ==== tb/exec_unit_tb.sv ====
`include "rv_settings.svh"

module exec_unit_tb
	import rv_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int PULSE_TIMEOUT = 20;

	logic      clk;
	logic      rst_n;
	logic      instr_valid;
	word_t     instr;
	word_t     pc;
	logic      wb_valid;
	reg_addr_t wb_rd;
	word_t     wb_data;
	logic      br_valid;
	logic      br_taken;
	word_t     br_target;
	logic      illegal;

	integer seed;
	// mirror of the architectural registers
	word_t  model [`RV_REG_COUNT];

	// the ten register operations as funct3 plus alt bit
	logic [2:0] op_f3 [10] = '{F3_ADD_SUB, F3_ADD_SUB, F3_SLL, F3_SLT, F3_SLTU,
		F3_XOR, F3_SRL_SRA, F3_SRL_SRA, F3_OR, F3_AND};
	logic       op_alt [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0,
		1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
	logic [2:0] br_f3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};

	exec_unit dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data),
		.br_valid    (br_valid),
		.br_taken    (br_taken),
		.br_target   (br_target),
		.illegal     (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
			$display("** FAIL **");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
			$display("** FAIL **");
			$fatal(1, "register index mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
			$display("** FAIL **");
			$fatal(1, "flag mismatch");
		end
	endtask

	// instruction encoders with fields in rv32i spec order
	function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic word_t i_type(input imm12_t imm, input reg_addr_t rs1,
		input logic [2:0] f3, input reg_addr_t rd);
		return {imm, rs1, f3, rd, OPC_OP_IMM};
	endfunction

	function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd);
		return {imm, rd, OPC_LUI};
	endfunction

	// off[0] is dropped by the format
	function automatic word_t b_type(input logic [12:0] off, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic word_t sext12(input imm12_t imm);
		return {{(`RV_XLEN-12){imm[11]}}, imm};
	endfunction

	// expected result of an OP / OP-IMM operation
	function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
		input word_t a, input word_t b);
		case (f3)
			F3_ADD_SUB: return alt ? a - b : a + b;
			F3_SLL:     return a << b[4:0];
			F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
			F3_XOR:     return a ^ b;
			F3_SRL_SRA: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			F3_OR:      return a | b;
			default:    return a & b;
		endcase
	endfunction

	// random register x1..x31
	function automatic reg_addr_t rand_reg();
		word_t r;
		r = $random(seed);
		return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
	endfunction

	function automatic logic pulse_of(input int kind);
		case (kind)
			0:       return wb_valid;
			1:       return br_valid;
			default: return illegal;
		endcase
	endfunction

	// entered at a falling edge with an instruction on the inputs
	// returns at the falling edge where the pulse is seen
	task automatic wait_pulse(input int kind, input string what);
		int   cycles;
		logic seen;
		cycles = 0;
		@(negedge clk);
		instr_valid = 1'b0;
		seen = pulse_of(kind);
		while (!seen) begin
			if (cycles >= PULSE_TIMEOUT) begin
				$display("no %s pulse within %0d cycles at %0t", what, PULSE_TIMEOUT, $time);
				$display("** FAIL **");
				$fatal(1, "pulse wait timed out");
			end
			cycles++;
			@(negedge clk);
			seen = pulse_of(kind);
		end
	endtask

	task automatic no_pulses();
		check_bit("wb_valid", 1'b0, wb_valid);
		check_bit("br_valid", 1'b0, br_valid);
		check_bit("illegal", 1'b0, illegal);
	endtask

	task automatic exec_write(input word_t ins, input reg_addr_t rd, input word_t exp);
		instr_valid = 1'b1;
		instr = ins;
		pc = '0;
		wait_pulse(0, "write-back");
		check_addr("wb_rd", rd, wb_rd);
		check_word("wb_data", exp, wb_data);
		// x0 keeps its zero
		if (rd != '0) begin
			model[rd] = exp;
		end
	endtask

	task automatic run_reg(input logic [2:0] f3, input logic alt, input reg_addr_t rd,
		input reg_addr_t rs1, input reg_addr_t rs2);
		word_t exp;
		exp = ref_alu(f3, alt, model[rs1], model[rs2]);
		exec_write(r_type(alt ? F7_ALT : F7_BASE, rs2, rs1, f3, rd), rd, exp);
	endtask

	task automatic run_imm(input logic [2:0] f3, input logic alt, input reg_addr_t rd,
		input reg_addr_t rs1, input imm12_t imm);
		imm12_t field;
		word_t  exp;
		field = imm;
		// shifts carry funct7 in the upper immediate bits
		if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
			field = {alt ? F7_ALT : F7_BASE, imm[4:0]};
		end
		exp = ref_alu(f3, alt, model[rs1], sext12(field));
		exec_write(i_type(field, rs1, f3, rd), rd, exp);
	endtask

	task automatic run_lui(input reg_addr_t rd, input logic [19:0] imm);
		exec_write(u_type(imm, rd), rd, {imm, 12'b0});
	endtask

	// lui then addi with the upper part rounded for the sign of the low twelve bits
	task automatic load_reg(input reg_addr_t rd, input word_t value);
		logic [19:0] hi;
		hi = value[31:12] + {19'b0, value[11]};
		run_lui(rd, hi);
		run_imm(F3_ADD_SUB, 1'b0, rd, rd, value[11:0]);
	endtask

	task automatic run_branch(input logic [2:0] f3, input reg_addr_t rs1,
		input reg_addr_t rs2, input word_t pc_v, input logic [12:0] off);
		word_t a;
		word_t b;
		logic  taken;
		a = model[rs1];
		b = model[rs2];
		case (f3)
			F3_BEQ:  taken = (a == b);
			F3_BNE:  taken = (a != b);
			F3_BLT:  taken = ($signed(a) < $signed(b));
			F3_BGE:  taken = ($signed(a) >= $signed(b));
			F3_BLTU: taken = (a < b);
			default: taken = (a >= b);
		endcase
		instr_valid = 1'b1;
		instr = b_type(off, rs2, rs1, f3);
		pc = pc_v;
		wait_pulse(1, "branch");
		check_bit("br_taken", taken, br_taken);
		check_word("br_target", pc_v + {{(`RV_XLEN-13){off[12]}}, off}, br_target);
	endtask

	task automatic exec_illegal(input word_t ins);
		instr_valid = 1'b1;
		instr = ins;
		pc = '0;
		wait_pulse(2, "illegal");
		check_bit("wb_valid", 1'b0, wb_valid);
		check_bit("br_valid", 1'b0, br_valid);
	endtask

	task automatic reset_clears_state();
		// outputs quiet during reset and just after
		@(negedge clk);
		no_pulses();
		// a write held on the inputs under reset must leave no trace
		instr_valid = 1'b1;
		instr = i_type(12'h7ff, 5'd0, F3_ADD_SUB, 5'd1);
		repeat (4) begin
			@(negedge clk);
			no_pulses();
		end
		instr_valid = 1'b0;
		rst_n = 1'b1;
		repeat (3) begin
			@(negedge clk);
			no_pulses();
		end
		// every register reads back zero
		for (int r = 0; r < `RV_REG_COUNT; r++) begin
			run_imm(F3_ADD_SUB, 1'b0, reg_addr_t'(r), reg_addr_t'(r), 12'h000);
		end
	endtask

	task automatic imm_ops();
		word_t     v;
		reg_addr_t s;
		reg_addr_t d;
		repeat (8) begin
			v = $random(seed);
			s = rand_reg();
			d = rand_reg();
			load_reg(s, v);
			v = $random(seed);
			run_imm(F3_ADD_SUB, 1'b0, d, s, v[11:0]);
			run_imm(F3_XOR, 1'b0, d, s, v[23:12]);
			run_imm(F3_OR, 1'b0, d, s, v[11:0]);
			run_imm(F3_AND, 1'b0, d, s, v[23:12]);
			run_imm(F3_SLT, 1'b0, d, s, v[11:0]);
			run_imm(F3_SLTU, 1'b0, d, s, v[23:12]);
			run_imm(F3_SLL, 1'b0, d, s, v[11:0]);
			run_imm(F3_SRL_SRA, 1'b0, d, s, v[23:12]);
			run_imm(F3_SRL_SRA, 1'b1, d, s, v[11:0]);
			run_lui(d, v[31:12]);
		end
	endtask

	task automatic reg_ops();
		word_t v;
		int    k;
		// signed and unsigned boundary values in x1..x5
		load_reg(5'd1, 32'h8000_0000);
		load_reg(5'd2, 32'h7fff_ffff);
		load_reg(5'd3, 32'hffff_ffff);
		load_reg(5'd4, 32'h0000_0000);
		load_reg(5'd5, 32'h0000_0001);
		for (int r = 6; r < 10; r++) begin
			load_reg(reg_addr_t'(r), $random(seed));
		end
		for (int i = 1; i < 6; i++) begin
			for (int j = 1; j < 6; j++) begin
				run_reg(F3_SLT, 1'b0, 5'd10, reg_addr_t'(i), reg_addr_t'(j));
				run_reg(F3_SLTU, 1'b0, 5'd10, reg_addr_t'(i), reg_addr_t'(j));
			end
		end
		// sra on negative values
		run_reg(F3_SRL_SRA, 1'b1, 5'd11, 5'd1, 5'd6);
		run_reg(F3_SRL_SRA, 1'b1, 5'd11, 5'd3, 5'd7);
		run_reg(F3_SRL_SRA, 1'b1, 5'd11, 5'd1, 5'd5);
		// back to back chain through x12
		load_reg(5'd12, $random(seed));
		for (int i = 0; i < 10; i++) begin
			run_reg(op_f3[i], op_alt[i], 5'd12, 5'd12, reg_addr_t'(6 + i % 4));
		end
		repeat (20) begin
			v = $random(seed);
			k = int'(v % 32'd10);
			run_reg(op_f3[k], op_alt[k], 5'd12, 5'd12, rand_reg());
		end
	endtask

	task automatic x0_writes();
		// write-back still pulses with the computed value
		run_reg(F3_ADD_SUB, 1'b0, 5'd0, 5'd6, 5'd7);
		run_imm(F3_OR, 1'b0, 5'd0, 5'd6, 12'h5a5);
		run_imm(F3_ADD_SUB, 1'b0, 5'd13, 5'd0, 12'h000);
		run_reg(F3_OR, 1'b0, 5'd14, 5'd6, 5'd0);
		run_reg(F3_ADD_SUB, 1'b0, 5'd15, 5'd0, 5'd0);
	endtask

	task automatic branch_conditions();
		reg_addr_t pa [8] = '{5'd1, 5'd4, 5'd1, 5'd3, 5'd4, 5'd5, 5'd4, 5'd6};
		reg_addr_t pb [8] = '{5'd2, 5'd1, 5'd4, 5'd4, 5'd3, 5'd4, 5'd5, 5'd3};
		word_t     v;
		word_t     w;
		load_reg(5'd1, 32'd5);
		load_reg(5'd2, 32'd5);
		load_reg(5'd3, 32'h8000_0000);
		load_reg(5'd4, 32'd1);
		load_reg(5'd5, 32'hffff_ffff);
		load_reg(5'd6, 32'h7fff_ffff);
		// equal, less, greater and sign-opposite pairs
		for (int f = 0; f < 6; f++) begin
			for (int p = 0; p < 8; p++) begin
				v = $random(seed);
				w = $random(seed);
				run_branch(br_f3[f], pa[p], pb[p], {v[31:2], 2'b00}, {w[12:1], 1'b0});
			end
		end
	endtask

	task automatic illegal_instrs();
		word_t v;
		v = $random(seed);
		load_reg(5'd7, v);
		// custom-0 opcode is not decoded
		exec_illegal({v[31:12], 5'd7, 7'b0001011});
		exec_illegal(r_type(7'b0000001, 5'd6, 5'd5, F3_ADD_SUB, 5'd7));
		// x7 still holds its old value
		run_imm(F3_ADD_SUB, 1'b0, 5'd8, 5'd7, 12'h000);
	endtask

	initial begin
		seed = 62456;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		pc = '0;
		for (int i = 0; i < `RV_REG_COUNT; i++) begin
			model[i] = '0;
		end
		reset_clears_state();
		imm_ops();
		reg_ops();
		x0_writes();
		branch_conditions();
		illegal_instrs();
		$display("** PASS **");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/alu.sv
hdl/inst_decode.sv
hdl/reg_file.sv
hdl/exec_unit.sv
tb/exec_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal \
		-f compile.f --top-module exec_unit_tb -o exec_unit_sim \
	&& ./obj_dir/exec_unit_sim \
	|| { echo "simulation did not complete successfully"; exit 1; }
